/* files.f */
+incdir+include
design/execPkg.sv
design/mcycleIf.sv
design/barrelShifter.sv
design/aluCore.sv
design/iterCounter.sv
design/shiftAddDatapath.sv
design/mcycleSeq.sv
design/execStage.sv
tb/execStageChecks.sv
tb/execStageTb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir \
		--top-module execStageTb -f files.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/execStageTb.sv */
`default_nettype none

`include "exec_consts.svh"

module execStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    import execPkg::*;

    localparam logic [31:0] lcgSeed = 32'ha6ed3e4e;
    localparam int halfPeriod = 10;
    localparam int driveDelay = 2;
    localparam int numAluRand = 40;
    localparam int numShift = 32;
    localparam int numMc = 9;
    localparam int numOverlapAlu = 40;
    localparam int numOverlapMc = 4;
    // Cycles from acceptance to push-in and to writeback
    localparam int pushOffset = `EXEC_ITER + 1;
    localparam int wbOffset = `EXEC_ITER + 2;
    localparam int cycleLimit = 16 + 3 * (numAluRand + numShift + numOverlapAlu
                                + wbOffset * (numMc + numOverlapMc)) / 2;

    typedef struct packed {
        int       due;
        regAddr_t dest;
        word_t    data;
        flags_t   flags;
    } wbEntry_t;

    logic                    CLK = 1'b0;
    logic                    rstN;
    logic                    opValid;
    opKind_t                 opKind;
    aluOp_t                  aluOp;
    shiftKind_t              shiftKind;
    logic [`EXEC_SHAMTW-1:0] shiftAmount;
    word_t                   srcA;
    word_t                   srcB;
    logic                    carryIn;
    regAddr_t                dest;
    logic                    ready;
    logic                    busy;
    logic                    wbValid;
    regAddr_t                wbDest;
    word_t                   wbData;
    flags_t                  wbFlags;

    // Model outputs for the current cycle
    logic                    expReady = 1'b1;
    logic                    expBusy = 1'b0;
    logic                    expWbValid = 1'b0;
    regAddr_t                expWbDest;
    word_t                   expWbData;
    flags_t                  expWbFlags;
    logic                    failed;

    logic [31:0]             lcgState = lcgSeed;
    aluOp_t                  opTable [8] = '{OP_AND, OP_EOR, OP_SUB, OP_RSB,
                                             OP_ADD, OP_ADC, OP_ORR, OP_MOV};
    wbEntry_t                wbQueue [$];
    wbEntry_t                mcEntry;
    logic                    mcPending = 1'b0;
    int                      mcPushCyc = 0;
    int                      modelCycle = 0;
    int                      cycleCount = 0;

    execStage i_execStage (
        .CLK         (CLK),
        .rstN        (rstN),
        .opValid     (opValid),
        .opKind      (opKind),
        .aluOp       (aluOp),
        .shiftKind   (shiftKind),
        .shiftAmount (shiftAmount),
        .srcA        (srcA),
        .srcB        (srcB),
        .carryIn     (carryIn),
        .dest        (dest),
        .ready       (ready),
        .busy        (busy),
        .wbValid     (wbValid),
        .wbDest      (wbDest),
        .wbData      (wbData),
        .wbFlags     (wbFlags)
    );

    execStageChecks i_execStageChecks (.*);

    always #halfPeriod CLK = ~CLK;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // One bit per step, carry is the last bit out
    function automatic logic [32:0] refShift(input shiftKind_t kind, input int amount,
                                             input word_t value, input logic cin);
        word_t v;
        logic  c;
        v = value;
        c = cin;
        for (int i = 0; i < amount; i++) begin
            if (kind == SH_LSL) begin
                c = v[31];
                v = v << 1;
            end else begin
                c = v[0];
                case (kind)
                    SH_LSR:  v = v >> 1;
                    SH_ASR:  v = {v[31], v[31:1]};
                    default: v = {v[0], v[31:1]};
                endcase
            end
        end
        return {c, v};
    endfunction

    function automatic logic [35:0] refAlu(input aluOp_t op, input word_t a, input word_t b,
                                           input logic cin, input logic shiftC);
        longint      sgn;
        logic [32:0] uns;
        logic        c;
        logic        isArith;
        word_t       r;
        flags_t      f;
        sgn = 0;
        isArith = 1'b1;
        case (op)
            OP_SUB: begin
                sgn = longint'($signed(a)) - longint'($signed(b));
                c   = a >= b;
            end
            OP_RSB: begin
                sgn = longint'($signed(b)) - longint'($signed(a));
                c   = b >= a;
            end
            OP_ADD, OP_ADC: begin
                sgn = longint'($signed(a)) + longint'($signed(b));
                uns = {1'b0, a} + {1'b0, b};
                if (op == OP_ADC) begin
                    sgn = sgn + longint'(cin);
                    uns = uns + 33'(cin);
                end
                c = uns[32];
            end
            default: begin
                c       = shiftC;
                isArith = 1'b0;
            end
        endcase
        case (op)
            OP_AND:  r = a & b;
            OP_EOR:  r = a ^ b;
            OP_ORR:  r = a | b;
            OP_MOV:  r = b;
            default: r = sgn[31:0];
        endcase
        f.n = r[31];
        f.z = r == '0;
        f.c = c;
        // Overflow when the true signed result does not fit
        f.v = isArith ? (sgn != longint'($signed(r))) : 1'b0;
        return {f, r};
    endfunction

    function automatic word_t refMulDiv(input opKind_t kind, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        if (kind == KIND_MUL) begin
            return prod[31:0];
        end else if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    // Mid-cycle, where inputs and outputs are stable
    always @(negedge CLK) begin
        wbEntry_t    e;
        logic        found;
        logic        pushNow;
        logic [32:0] shOut;
        logic [35:0] aluOut;
        modelCycle = modelCycle + 1;
        expBusy    = mcPending && (modelCycle <= mcPushCyc);
        pushNow    = mcPending && (modelCycle == mcPushCyc);
        expReady   = !pushNow && ((opKind == KIND_ALU) || !expBusy);
        found      = 1'b0;
        if (wbQueue.size() > 0 && wbQueue[0].due == modelCycle) begin
            e     = wbQueue.pop_front();
            found = 1'b1;
        end else if (mcPending && mcEntry.due == modelCycle) begin
            e         = mcEntry;
            mcPending = 1'b0;
            found     = 1'b1;
        end
        expWbValid = found;
        if (found) begin
            expWbDest  = e.dest;
            expWbData  = e.data;
            expWbFlags = e.flags;
        end
        // Accepted at the coming edge
        if (opValid && expReady) begin
            if (opKind == KIND_ALU) begin
                shOut   = refShift(shiftKind, int'(shiftAmount), srcB, carryIn);
                aluOut  = refAlu(aluOp, srcA, shOut[31:0], carryIn, shOut[32]);
                e.due   = modelCycle + 1;
                e.dest  = dest;
                e.data  = aluOut[31:0];
                e.flags = aluOut[35:32];
                wbQueue.push_back(e);
            end else begin
                mcEntry.due   = modelCycle + wbOffset;
                mcEntry.dest  = dest;
                mcEntry.data  = refMulDiv(opKind, srcA, srcB);
                mcEntry.flags = '0;
                mcPushCyc     = modelCycle + pushOffset;
                mcPending     = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Offer one operation and hold it until ready
    task automatic issueOp(input opKind_t kind, input aluOp_t op, input shiftKind_t shk,
                           input logic [`EXEC_SHAMTW-1:0] amt, input word_t a, input word_t b);
        logic [31:0] r;
        logic        took;
        r           = nextRand();
        opKind      = kind;
        aluOp       = op;
        shiftKind   = shk;
        shiftAmount = amt;
        srcA        = a;
        srcB        = b;
        carryIn     = r[31];
        dest        = regAddr_t'(r >> 24);
        opValid     = 1'b1;
        took        = 1'b0;
        while (!took) begin
            @(negedge CLK);
            took = ready;
            @(posedge CLK);
        end
        #driveDelay;
        opValid = 1'b0;
    endtask

    always @(posedge failed) begin
        abortRun("A check against the reference model failed");
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            abortRun("Timeout: the run went past its cycle limit");
        end
    end

    initial begin
        logic [31:0] r;
        word_t       a;
        word_t       b;
        rstN        = 1'b0;
        opValid     = 1'b0;
        opKind      = KIND_ALU;
        aluOp       = OP_AND;
        shiftKind   = SH_LSL;
        shiftAmount = '0;
        srcA        = '0;
        srcB        = '0;
        carryIn     = 1'b0;
        dest        = '0;
        repeat (16) @(posedge CLK);
        #driveDelay;
        rstN = 1'b1;

        // Shifter bypassed, equal operands now and then for Z
        for (int i = 0; i < numAluRand; i++) begin
            r = nextRand();
            a = nextRand();
            b = (i % 8 == 7) ? a : nextRand();
            issueOp(KIND_ALU, opTable[r[31:29]], shiftKind_t'(r[27:26]), '0, a, b);
        end

        // Every shift kind, zero amount included
        for (int i = 0; i < numShift; i++) begin
            r = nextRand();
            issueOp(KIND_ALU, (i % 2 == 0) ? OP_MOV : OP_AND, shiftKind_t'(i % 4),
                    ((i / 4) % 4 == 0) ? '0 : r[31:27], nextRand(), nextRand());
        end

        // Back to back, so each waits for the previous push-in
        for (int i = 0; i < numMc; i++) begin
            a = nextRand();
            b = nextRand() >> (4 * (i % 8));
            if (i == numMc - 1) begin
                b = '0;
            end
            issueOp((i < 4) ? KIND_MUL : KIND_DIV, OP_AND, SH_LSL, '0, a, b);
        end

        // ALU stream under a multiply, one of them meets the push-in cycle
        issueOp(KIND_MUL, OP_AND, SH_LSL, '0, nextRand(), nextRand());
        for (int i = 0; i < numOverlapAlu; i++) begin
            r = nextRand();
            issueOp(KIND_ALU, opTable[r[31:29]], shiftKind_t'(r[27:26]), r[25:21],
                    nextRand(), nextRand());
        end
        issueOp(KIND_MUL, OP_AND, SH_LSL, '0, nextRand(), nextRand());
        issueOp(KIND_MUL, OP_AND, SH_LSL, '0, nextRand(), nextRand());
        issueOp(KIND_DIV, OP_AND, SH_LSL, '0, nextRand(), nextRand() >> 12);

        while (mcPending || wbQueue.size() > 0) begin
            @(negedge CLK);
        end
        repeat (2) @(posedge CLK);
        if (failed) begin
            abortRun("Run ended with a failed check");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/execStageChecks.sv */
`default_nettype none

module execStageChecks (
    input  logic              CLK,
    input  logic              ready,
    input  logic              busy,
    input  logic              wbValid,
    input  execPkg::regAddr_t wbDest,
    input  execPkg::word_t    wbData,
    input  execPkg::flags_t   wbFlags,
    input  logic              expReady,
    input  logic              expBusy,
    input  logic              expWbValid,
    input  execPkg::regAddr_t expWbDest,
    input  execPkg::word_t    expWbData,
    input  execPkg::flags_t   expWbFlags,
    output logic              failed
);
    timeunit 1ns;
    timeprecision 1ps;

    import execPkg::*;

    logic checkOn = 1'b0;
    logic failFlag = 1'b0;

    assign failed = failFlag;

    // Outputs are known once the first edge has seen reset
    always @(posedge CLK) begin
        checkOn <= 1'b1;
    end

    task automatic reportMismatch(input string name, input word_t expV, input word_t gotV);
        $display("ERR %s exp %h got %h at %0t", name, expV, gotV, $time);
        failFlag = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Issue side and status
    //////////////////////////////////////////////////////////////////////

    readyMatch: assert property (@(posedge CLK) checkOn |-> ready == expReady)
        else reportMismatch("ready", word_t'($sampled(expReady)), word_t'($sampled(ready)));

    busyMatch: assert property (@(posedge CLK) checkOn |-> busy == expBusy)
        else reportMismatch("busy", word_t'($sampled(expBusy)), word_t'($sampled(busy)));

    //////////////////////////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////////////////////////

    wbValidMatch: assert property (@(posedge CLK) checkOn |-> wbValid == expWbValid)
        else reportMismatch("wbValid", word_t'($sampled(expWbValid)),
                            word_t'($sampled(wbValid)));

    // Payload only matters in a writeback cycle
    wbDestMatch: assert property (@(posedge CLK) checkOn && expWbValid |-> wbDest == expWbDest)
        else reportMismatch("wbDest", word_t'($sampled(expWbDest)), word_t'($sampled(wbDest)));

    wbDataMatch: assert property (@(posedge CLK) checkOn && expWbValid |-> wbData == expWbData)
        else reportMismatch("wbData", $sampled(expWbData), $sampled(wbData));

    wbFlagsMatch: assert property (@(posedge CLK)
        checkOn && expWbValid |-> wbFlags == expWbFlags)
        else reportMismatch("wbFlags", word_t'($sampled(expWbFlags)),
                            word_t'($sampled(wbFlags)));

endmodule

`default_nettype wire

/* design/execStage.sv */
`default_nettype none

`include "exec_consts.svh"

module execStage (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic                    opValid,
    input  execPkg::opKind_t        opKind,
    input  execPkg::aluOp_t         aluOp,
    input  execPkg::shiftKind_t     shiftKind,
    input  logic [`EXEC_SHAMTW-1:0] shiftAmount,
    input  execPkg::word_t          srcA,
    input  execPkg::word_t          srcB,
    input  logic                    carryIn,
    input  execPkg::regAddr_t       dest,
    output logic                    ready,
    output logic                    busy,
    output logic                    wbValid,
    output execPkg::regAddr_t       wbDest,
    output execPkg::word_t          wbData,
    output execPkg::flags_t         wbFlags
);
    import execPkg::*;

    logic     isAlu;
    logic     aluAccept;
    logic     mcRequest;
    word_t    shiftedB;
    logic     shiftCarry;
    word_t    aluResult;
    flags_t   aluFlags;
    regAddr_t mcDest;

    mcycleIf mcBus ();

    //////////////////////////////////////////////////////////////////////
    // Issue
    //////////////////////////////////////////////////////////////////////

    // Push-in owns the writeback slot, a running unit blocks new MUL/DIV
    assign isAlu     = opKind == KIND_ALU;
    assign ready     = !mcBus.push && (isAlu || !mcBus.busy);
    assign aluAccept = opValid && ready && isAlu;
    assign mcRequest = opValid && ready && !isAlu;
    assign busy      = mcBus.busy;

    barrelShifter i_barrelShifter (
        .kind     (shiftKind),
        .amount   (shiftAmount),
        .value    (srcB),
        .carryIn  (carryIn),
        .shifted  (shiftedB),
        .carryOut (shiftCarry)
    );

    aluCore i_aluCore (
        .op         (aluOp),
        .srcA       (srcA),
        .srcB       (shiftedB),
        .carryIn    (carryIn),
        .shiftCarry (shiftCarry),
        .result     (aluResult),
        .flags      (aluFlags)
    );

    //////////////////////////////////////////////////////////////////////
    // Multi-cycle unit
    //////////////////////////////////////////////////////////////////////

    mcycleSeq i_mcycleSeq (
        .CLK     (CLK),
        .rstN    (rstN),
        .request (mcRequest),
        .seqPort (mcBus.seq)
    );

    iterCounter i_iterCounter (
        .CLK     (CLK),
        .rstN    (rstN),
        .cntPort (mcBus.cnt)
    );

    // Operands go in unshifted
    shiftAddDatapath i_shiftAddDatapath (
        .CLK    (CLK),
        .rstN   (rstN),
        .kind   (opKind),
        .opA    (srcA),
        .opB    (srcB),
        .dpPort (mcBus.dp)
    );

    // Destination tag held until push-in
    always_ff @(posedge CLK) begin
        if (mcBus.start) begin
            mcDest <= dest;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= mcBus.push || aluAccept;
        end
    end

    always_ff @(posedge CLK) begin
        if (mcBus.push) begin
            wbDest  <= mcDest;
            wbData  <= mcBus.result;
            wbFlags <= '0;
        end else if (aluAccept) begin
            wbDest  <= dest;
            wbData  <= aluResult;
            wbFlags <= aluFlags;
        end
    end

endmodule

`default_nettype wire

/* design/mcycleSeq.sv */
`default_nettype none

`include "exec_consts.svh"

module mcycleSeq (
    input  logic CLK,
    input  logic rstN,
    input  logic request,
    mcycleIf.seq seqPort
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_PUSH
    } state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            ST_IDLE: begin
                if (request) begin
                    nextState = ST_RUN;
                end
            end
            ST_RUN: begin
                if (seqPort.last) begin
                    nextState = ST_PUSH;
                end
            end
            // One cycle to hand the result to writeback
            ST_PUSH: nextState = ST_IDLE;
            default: nextState = ST_IDLE;
        endcase
    end

    assign seqPort.start = (state == ST_IDLE) && request;
    assign seqPort.step  = state == ST_RUN;
    assign seqPort.push  = state == ST_PUSH;
    assign seqPort.busy  = state != ST_IDLE;

    // Counter has to flag last after exactly EXEC_ITER steps
    pushTiming: assert property (@(posedge CLK) disable iff (!rstN)
        seqPort.push |-> $past(seqPort.start, `EXEC_ITER + 1));

endmodule

`default_nettype wire

/* design/shiftAddDatapath.sv */
`default_nettype none

`include "exec_consts.svh"

module shiftAddDatapath (
    input  logic             CLK,
    input  logic             rstN,
    input  execPkg::opKind_t kind,
    input  execPkg::word_t   opA,
    input  execPkg::word_t   opB,
    mcycleIf.dp              dpPort
);
    import execPkg::*;

    logic                isDiv;

    // Product, or partial remainder
    word_t               acc;
    // Multiplicand, or dividend turning into quotient
    word_t               regA;
    // Multiplier, or divisor
    word_t               regB;

    logic [`EXEC_XLEN:0] remShift;
    logic [`EXEC_XLEN:0] trial;
    logic                fits;
    word_t               addend;

    //////////////////////////////////////////////////////////////////////
    // Per-step arithmetic
    //////////////////////////////////////////////////////////////////////

    // Next dividend bit enters the remainder
    assign remShift = {acc, regA[`EXEC_XLEN-1]};
    assign trial    = remShift - {1'b0, regB};
    assign fits     = !trial[`EXEC_XLEN];

    assign addend   = regB[0] ? regA : '0;

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            isDiv <= 1'b0;
        end else if (dpPort.start) begin
            isDiv <= kind == KIND_DIV;
        end
    end

    // Both operations load the same way
    always_ff @(posedge CLK) begin
        if (dpPort.start) begin
            acc  <= '0;
            regA <= opA;
            regB <= opB;
        end else if (dpPort.step) begin
            if (isDiv) begin
                // Restore on a failed subtract
                acc  <= fits ? trial[`EXEC_XLEN-1:0] : remShift[`EXEC_XLEN-1:0];
                regA <= {regA[`EXEC_XLEN-2:0], fits};
            end else begin
                acc  <= acc + addend;
                regA <= regA << 1;
                regB <= regB >> 1;
            end
        end
    end

    // A zero divisor always fits, so the quotient fills with ones
    assign dpPort.result = isDiv ? regA : acc;

endmodule

`default_nettype wire

/* design/iterCounter.sv */
`default_nettype none

`include "exec_consts.svh"

module iterCounter (
    input  logic CLK,
    input  logic rstN,
    mcycleIf.cnt cntPort
);

    localparam int unsigned lastStep = `EXEC_ITER - 1;

    logic [`EXEC_CNTW-1:0] count;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (cntPort.start) begin
            count <= '0;
        end else if (cntPort.step) begin
            count <= count + 1'b1;
        end
    end

    assign cntPort.last = cntPort.step && (count == lastStep[`EXEC_CNTW-1:0]);

    // Sequencer stops stepping once last has been seen
    stepBound: assert property (@(posedge CLK) disable iff (!rstN)
        cntPort.step |-> count <= lastStep[`EXEC_CNTW-1:0]);

endmodule

`default_nettype wire

/* design/aluCore.sv */
`default_nettype none

`include "exec_consts.svh"

module aluCore (
    input  execPkg::aluOp_t op,
    input  execPkg::word_t  srcA,
    input  execPkg::word_t  srcB,
    input  logic            carryIn,
    input  logic            shiftCarry,
    output execPkg::word_t  result,
    output execPkg::flags_t flags
);
    import execPkg::*;

    word_t               addX;
    word_t               addY;
    logic                addCin;
    logic [`EXEC_XLEN:0] addSum;
    logic                isArith;

    // Steer operands onto the shared adder
    always_comb begin
        addX   = srcA;
        addY   = srcB;
        addCin = 1'b0;
        case (op)
            OP_SUB: begin
                addY   = ~srcB;
                addCin = 1'b1;
            end
            OP_RSB: begin
                addX   = srcB;
                addY   = ~srcA;
                addCin = 1'b1;
            end
            OP_ADC:  addCin = carryIn;
            default: addCin = 1'b0;
        endcase
    end

    assign addSum  = {1'b0, addX} + {1'b0, addY} + {{`EXEC_XLEN{1'b0}}, addCin};
    assign isArith = (op == OP_SUB) || (op == OP_RSB) || (op == OP_ADD) || (op == OP_ADC);

    always_comb begin
        case (op)
            OP_AND:  result = srcA & srcB;
            OP_EOR:  result = srcA ^ srcB;
            OP_ORR:  result = srcA | srcB;
            OP_MOV:  result = srcB;
            default: result = addSum[`EXEC_XLEN-1:0];
        endcase
    end

    always_comb begin
        flags.n = result[`EXEC_XLEN-1];
        flags.z = result == '0;
        if (isArith) begin
            // Carry is not-borrow for the subtracts
            flags.c = addSum[`EXEC_XLEN];
            flags.v = (addX[`EXEC_XLEN-1] == addY[`EXEC_XLEN-1])
                   && (addSum[`EXEC_XLEN-1] != addX[`EXEC_XLEN-1]);
        end else begin
            flags.c = shiftCarry;
            flags.v = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/barrelShifter.sv */
`default_nettype none

`include "exec_consts.svh"

module barrelShifter (
    input  execPkg::shiftKind_t     kind,
    input  logic [`EXEC_SHAMTW-1:0] amount,
    input  execPkg::word_t          value,
    input  logic                    carryIn,
    output execPkg::word_t          shifted,
    output logic                    carryOut
);
    import execPkg::*;

    logic [`EXEC_SHAMTW-1:0] rightIdx;
    logic [`EXEC_SHAMTW-1:0] leftIdx;
    logic [2*`EXEC_XLEN-1:0] rotated;

    // Position of the last bit shifted out
    assign rightIdx = amount - 1'b1;
    // Equals 32 minus amount for a nonzero amount
    assign leftIdx  = ~rightIdx;

    assign rotated  = {value, value} >> amount;

    always_comb begin
        shifted  = value;
        carryOut = carryIn;
        if (amount != '0) begin
            carryOut = value[rightIdx];
            case (kind)
                SH_LSL: begin
                    shifted  = value << amount;
                    carryOut = value[leftIdx];
                end
                SH_LSR:  shifted = value >> amount;
                SH_ASR:  shifted = $signed(value) >>> amount;
                SH_ROR:  shifted = rotated[`EXEC_XLEN-1:0];
                default: shifted = value;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/mcycleIf.sv */
`default_nettype none

interface mcycleIf;
    import execPkg::*;

    // Control from the sequencer
    logic  start;
    logic  step;
    logic  push;
    logic  busy;

    // Final iteration flag from the counter
    logic  last;

    word_t result;

    modport seq (output start, output step, output push, output busy, input last);
    modport cnt (input start, input step, output last);
    modport dp  (input start, input step, output result);

endinterface

`default_nettype wire

/* design/execPkg.sv */
`default_nettype none

`include "exec_consts.svh"

package execPkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;
    typedef logic [`EXEC_RAW-1:0]  regAddr_t;

    // ARM data-processing opcode field
    typedef enum logic [`EXEC_OPW-1:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_RSB = 4'b0011,
        OP_ADD = 4'b0100,
        OP_ADC = 4'b0101,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } aluOp_t;

    typedef enum logic [`EXEC_SHKW-1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shiftKind_t;

    typedef enum logic [`EXEC_KINDW-1:0] {
        KIND_ALU = 2'd0,
        KIND_MUL = 2'd1,
        KIND_DIV = 2'd2
    } opKind_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

/* include/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data word and register number widths
`define EXEC_XLEN   32
`define EXEC_RAW    4

// Iterations of a multiply or divide
`define EXEC_ITER   32

// Wide enough to hold EXEC_ITER itself
`define EXEC_CNTW   6

// Instruction field widths
`define EXEC_OPW    4
`define EXEC_SHKW   2
`define EXEC_KINDW  2
`define EXEC_SHAMTW 5

`endif
